/* Makefile */
SIM       := verilator
TOP       := mipsCoreTb
FILELIST  := src.f
BUILD_DIR := obj_dir
SIMFLAGS  := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
PASS_TEXT := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* source/aluUnit.sv */
// ==========================================================================
// aluUnit
// add, sub, and, or and unsigned set-less-than with a zero flag
// ==========================================================================

module aluUnit (
  input  logic [mipsPkg::dataWidth-1:0] opA,
  input  logic [mipsPkg::dataWidth-1:0] opB,
  input  mipsPkg::aluOpT                op,
  output logic [mipsPkg::dataWidth-1:0] result,
  output logic                          zero
);
  import mipsPkg::*;

  always_comb begin
    unique case (op)
      aluAdd: begin
        result = opA + opB;
      end
      aluSub: begin
        result = opA - opB;
      end
      aluAnd: begin
        result = opA & opB;
      end
      aluOr: begin
        result = opA | opB;
      end
      aluSlt: begin
        // unsigned compare, 0 or 1
        result = {{(dataWidth-1){1'b0}}, (opA < opB)};
      end
      default: begin
        // aluNone and anything unexpected
        result = '0;
      end
    endcase
  end

  // flag for any result, beq reads it after sub
  assign zero = (result == '0);

endmodule

/* source/ctrlIf.sv */
// ==========================================================================
// ctrlIf
// decoded control bundle from the instruction decoder to the datapath
// and the program counter
// ==========================================================================

interface ctrlIf;
  import mipsPkg::*;

  // write-back destination and source selects
  logic  regDst;
  logic  aluSrc;
  logic  memToReg;
  logic  link;
  // state-changing enables
  logic  regWrite;
  logic  memWrite;
  // next-pc selects
  logic  branch;
  logic  jump;
  // ALU operation
  aluOpT aluOp;

  // decoder drives everything
  modport dec (output regDst, aluSrc, memToReg, regWrite, memWrite,
               branch, jump, link, aluOp);
  // datapath view of the bundle
  modport path (input regDst, aluSrc, memToReg, regWrite, memWrite,
                branch, jump, link, aluOp);
  // sequencer only cares about control flow
  modport seq (input branch, jump);

endinterface

/* source/mainDecoder.sv */
// ==========================================================================
// mainDecoder
// combinational decode of opcode and funct into the control bundle,
// with the ALU control folded in; illegal encodings write nothing
// ==========================================================================

module mainDecoder (
  input  logic [5:0] opcode,
  input  logic [5:0] funct,
  ctrlIf.dec         ctrl
);
  import mipsPkg::*;

  // R-type ALU op from funct, aluNone when funct is not supported
  aluOpT rOp;

  always_comb begin
    unique case (funct)
      fnAdd:   rOp = aluAdd;
      fnSub:   rOp = aluSub;
      fnAnd:   rOp = aluAnd;
      fnOr:    rOp = aluOr;
      fnSlt:   rOp = aluSlt;
      default: rOp = aluNone;
    endcase
  end

  // ========================================================================
  // main decode
  // ========================================================================

  always_comb begin
    // defaults behave as a nop
    ctrl.regDst   = 1'b0;
    ctrl.aluSrc   = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.regWrite = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.jump     = 1'b0;
    ctrl.link     = 1'b0;
    ctrl.aluOp    = aluNone;

    unique case (opcode)
      opR: begin
        // rd destination, write only for a known funct
        ctrl.regDst   = 1'b1;
        ctrl.aluOp    = rOp;
        ctrl.regWrite = (rOp != aluNone);
      end
      opLw: begin
        // base + offset, load into rt
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq: begin
        // equality from zero flag of rs - rt
        ctrl.branch   = 1'b1;
        ctrl.aluOp    = aluSub;
      end
      opJ: begin
        ctrl.jump     = 1'b1;
      end
      opJal: begin
        // pc + 8 into r31
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // unknown opcode, keep the nop defaults
        ctrl.aluOp    = aluNone;
      end
    endcase
  end

endmodule

/* source/mipsCore.sv */
// ==========================================================================
// mipsCore
// single-cycle MIPS subset core: field split, immediate extension,
// operand and write-back muxes, external instruction and data memories
// ==========================================================================

module mipsCore #(
  parameter int dmemAddrWidth = 7
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [mipsPkg::dataWidth-1:0] instr,
  output logic [mipsPkg::dataWidth-1:0] instrAddr,
  input  logic [mipsPkg::dataWidth-1:0] memReadData,
  output logic [dmemAddrWidth-1:0]      memAddr,
  output logic [mipsPkg::dataWidth-1:0] memWriteData,
  output logic                          memWriteEn,
  output logic [mipsPkg::dataWidth-1:0] rfWriteData
);
  import mipsPkg::*;

  // ========================================================================
  // instruction fields
  // ========================================================================

  logic [5:0]           opcode;
  logic [4:0]           rs;
  logic [4:0]           rt;
  logic [4:0]           rd;
  logic [15:0]          imm;
  logic [25:0]          jumpIndex;
  logic [5:0]           funct;
  // datapath
  logic [dataWidth-1:0] immExt;
  logic [dataWidth-1:0] readDataA;
  logic [dataWidth-1:0] readDataB;
  logic [dataWidth-1:0] aluB;
  logic [dataWidth-1:0] aluResult;
  logic                 aluZero;
  logic [dataWidth-1:0] pc;
  logic [dataWidth-1:0] pcPlus8;
  logic [4:0]           writeAddr;
  logic                 regWriteEn;

  assign opcode    = instr[31:26];
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign imm       = instr[15:0];
  assign jumpIndex = instr[25:0];
  assign funct     = instr[5:0];

  // sign extension for lw/sw offsets and branch displacement
  assign immExt = {{(dataWidth-16){imm[15]}}, imm};

  // ========================================================================
  // control
  // ========================================================================

  ctrlIf ctrl ();

  mainDecoder uDecoder (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  programCounter uPc (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .zero         (aluZero),
    .branchOffset (immExt),
    .jumpIndex    (jumpIndex),
    .pc           (pc),
    .pcPlus8      (pcPlus8)
  );

  // ========================================================================
  // datapath
  // ========================================================================

  // destination: jal -> r31, R-type -> rd, lw -> rt
  assign writeAddr = ctrl.link ? linkReg : (ctrl.regDst ? rd : rt);
  // no state change while held in reset
  assign regWriteEn = ctrl.regWrite & rst;

  registerFile uRegs (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (regWriteEn),
    .readAddrA (rs),
    .readAddrB (rt),
    .writeAddr (writeAddr),
    .writeData (rfWriteData),
    .readDataA (readDataA),
    .readDataB (readDataB)
  );

  // second operand, immediate for memory ops
  assign aluB = ctrl.aluSrc ? immExt : readDataB;

  aluUnit uAlu (
    .opA    (readDataA),
    .opB    (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // write-back source: return address, load data or ALU result
  always_comb begin
    if (ctrl.link) begin
      rfWriteData = pcPlus8;
    end else if (ctrl.memToReg) begin
      rfWriteData = memReadData;
    end else begin
      rfWriteData = aluResult;
    end
  end

  // ========================================================================
  // memory ports
  // ========================================================================

  assign instrAddr    = pc;
  // word index from low bits of base + offset
  assign memAddr      = aluResult[dmemAddrWidth-1:0];
  assign memWriteData = readDataB;
  assign memWriteEn   = ctrl.memWrite & rst;

endmodule

/* source/mipsPkg.sv */
// ==========================================================================
// mipsPkg
// shared constants for the single-cycle MIPS core: word width, major
// opcodes, R-type function codes, ALU operations and the link register
// ==========================================================================

package mipsPkg;

  // ========================================================================
  // widths
  // ========================================================================

  // data and instruction word
  localparam int dataWidth = 32;

  // ========================================================================
  // major opcodes, instr[31:26]
  // ========================================================================

  // all R-type ops share opcode 0 and are told apart by funct
  localparam logic [5:0] opR   = 6'b000000;
  localparam logic [5:0] opLw  = 6'b100011;
  localparam logic [5:0] opSw  = 6'b101011;
  localparam logic [5:0] opBeq = 6'b000100;
  localparam logic [5:0] opJ   = 6'b000010;
  localparam logic [5:0] opJal = 6'b000011;

  // ========================================================================
  // R-type function codes, instr[5:0]
  // ========================================================================

  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;

  // ========================================================================
  // ALU operations
  // ========================================================================

  // aluNone marks an illegal or non-ALU instruction, result forced to 0
  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOr   = 3'd3,
    aluSlt  = 3'd4,
    aluNone = 3'd7
  } aluOpT;

  // ========================================================================
  // registers
  // ========================================================================

  // jal destination, holds the return address pc + 8
  localparam logic [4:0] linkReg = 5'd31;

endpackage

/* source/programCounter.sv */
// ==========================================================================
// programCounter
// pc register with sequential, branch and jump next-address selection
// ==========================================================================

module programCounter (
  input  logic                          clk,
  input  logic                          rst,
  ctrlIf.seq                            ctrl,
  input  logic                          zero,
  input  logic [mipsPkg::dataWidth-1:0] branchOffset,
  input  logic [25:0]                   jumpIndex,
  output logic [mipsPkg::dataWidth-1:0] pc,
  output logic [mipsPkg::dataWidth-1:0] pcPlus8
);
  import mipsPkg::*;

  logic [dataWidth-1:0] pcPlus4;
  logic [dataWidth-1:0] branchTarget;
  logic [dataWidth-1:0] jumpTarget;
  logic [dataWidth-1:0] pcNext;

  assign pcPlus4 = pc + dataWidth'(4);
  assign pcPlus8 = pc + dataWidth'(8);

  // word offset relative to the delay-free next instruction
  assign branchTarget = pcPlus4 + {branchOffset[dataWidth-3:0], 2'b00};
  // pseudo-direct, region from upper bits of pc + 4
  assign jumpTarget = {pcPlus4[dataWidth-1:dataWidth-4], jumpIndex, 2'b00};

  // jump wins over branch; branch only when the compare was equal
  always_comb begin
    if (ctrl.jump) begin
      pcNext = jumpTarget;
    end else if (ctrl.branch && zero) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

/* source/registerFile.sv */
// ==========================================================================
// registerFile
// 32 x 32 general registers, two combinational reads, one clocked write,
// r0 reads as zero and ignores writes
// ==========================================================================

module registerFile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          writeEn,
  input  logic [4:0]                    readAddrA,
  input  logic [4:0]                    readAddrB,
  input  logic [4:0]                    writeAddr,
  input  logic [mipsPkg::dataWidth-1:0] writeData,
  output logic [mipsPkg::dataWidth-1:0] readDataA,
  output logic [mipsPkg::dataWidth-1:0] readDataB
);
  import mipsPkg::*;

  logic [dataWidth-1:0] regs [32];

  // ========================================================================
  // write port
  // ========================================================================

  // whole file cleared on reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != 5'd0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // ========================================================================
  // read ports
  // ========================================================================

  // r0 hardwired to zero
  always_comb begin
    readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
    readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];
  end

endmodule

/* src.f */
source/mipsPkg.sv
source/ctrlIf.sv
source/mainDecoder.sv
source/programCounter.sv
source/registerFile.sv
source/aluUnit.sv
source/mipsCore.sv
tests/mipsCore_chk.sv
tests/mipsCoreTb.sv

/* tests/mipsCoreTb.sv */
// ==========================================================================
// mipsCoreTb
// testbench for the single-cycle core: memory models, LFSR-built program,
// ISA-level golden model and concurrent compare assertions
// ==========================================================================

module mipsCoreTb;
  timeunit 1ns;
  timeprecision 100ps;
  import mipsPkg::*;

  localparam int resetCycles = 16;
  localparam int maxCycles   = resetCycles + 300;

  logic                 clk;
  logic                 rst;
  logic [dataWidth-1:0] instr;
  logic [dataWidth-1:0] instrAddr;
  logic [dataWidth-1:0] memReadData;
  logic [6:0]           memAddr;
  logic [dataWidth-1:0] memWriteData;
  logic                 memWriteEn;
  logic [dataWidth-1:0] rfWriteData;

  logic [dataWidth-1:0] imem [64];
  logic [dataWidth-1:0] dmem [128];
  logic [31:0]          lfsrState;
  int                   progLen;
  int                   haltIndex;
  int                   cycleCount = 0;

  mipsCore #(.dmemAddrWidth(7)) UUT (
    .clk          (clk),
    .rst          (rst),
    .instr        (instr),
    .instrAddr    (instrAddr),
    .memReadData  (memReadData),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memWriteEn   (memWriteEn),
    .rfWriteData  (rfWriteData)
  );

  bind mipsCore mipsCore_chk pcWriteChk (
    .clk        (clk),
    .rst        (rst),
    .instr      (instr),
    .instrAddr  (instrAddr),
    .memWriteEn (memWriteEn),
    .regWriteEn (regWriteEn)
  );

  always #50 clk = ~clk;

  // ========================================================================
  // memory models
  // ========================================================================

  // word-indexed, both answer combinationally
  assign instr       = imem[instrAddr[7:2]];
  assign memReadData = dmem[memAddr];

  function automatic logic [dataWidth-1:0] fillWord(input int addr);
    return (32'h9e3779b9 * 32'(addr + 1)) ^ 32'h5a5a0000;
  endfunction

  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 128; i++) begin
        dmem[i] <= fillWord(i);
      end
    end else if (memWriteEn) begin
      dmem[memAddr] <= memWriteData;
    end
  end

  // ========================================================================
  // golden model
  // ========================================================================

  logic [dataWidth-1:0] mRegs [32];
  logic [dataWidth-1:0] mMem [128];
  logic [dataWidth-1:0] mPc;
  logic [dataWidth-1:0] mInstr;
  logic [dataWidth-1:0] expA;
  logic [dataWidth-1:0] expB;
  logic [dataWidth-1:0] expImm;
  logic [dataWidth-1:0] expSum;
  logic [dataWidth-1:0] expWb;
  logic [dataWidth-1:0] expNextPc;
  logic [dataWidth-1:0] pcPlus4;
  logic [4:0]           expDest;
  logic                 expWrite;
  logic                 expStore;

  // ISA rules for the next state and the visible outputs
  always_comb begin
    mInstr    = imem[mPc[7:2]];
    expA      = mRegs[mInstr[25:21]];
    expB      = mRegs[mInstr[20:16]];
    expImm    = {{16{mInstr[15]}}, mInstr[15:0]};
    expSum    = expA + expImm;
    pcPlus4   = mPc + 32'd4;
    expNextPc = pcPlus4;
    expDest   = mInstr[15:11];
    expWb     = '0;
    expWrite  = 1'b0;
    expStore  = 1'b0;
    case (mInstr[31:26])
      opR: begin
        expWrite = 1'b1;
        case (mInstr[5:0])
          fnAdd:   expWb = expA + expB;
          fnSub:   expWb = expA - expB;
          fnAnd:   expWb = expA & expB;
          fnOr:    expWb = expA | expB;
          fnSlt:   expWb = {31'd0, expA < expB};
          default: expWrite = 1'b0;
        endcase
      end
      opLw: begin
        expDest  = mInstr[20:16];
        expWrite = 1'b1;
        expWb    = mMem[expSum[6:0]];
      end
      opSw: expStore = 1'b1;
      opBeq: begin
        if (expA == expB) begin
          expNextPc = pcPlus4 + {expImm[29:0], 2'b00};
        end
      end
      opJ: expNextPc = {pcPlus4[31:28], mInstr[25:0], 2'b00};
      opJal: begin
        expNextPc = {pcPlus4[31:28], mInstr[25:0], 2'b00};
        expDest   = linkReg;
        expWrite  = 1'b1;
        expWb     = mPc + 32'd8;
      end
      default: expWrite = 1'b0;
    endcase
  end

  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      mPc <= '0;
      for (int i = 0; i < 32; i++) begin
        mRegs[i] <= '0;
      end
      for (int i = 0; i < 128; i++) begin
        mMem[i] <= fillWord(i);
      end
    end else begin
      // r0 never written, stays zero
      if (expWrite && expDest != 5'd0) begin
        mRegs[expDest] <= expWb;
      end
      if (expStore) begin
        mMem[expSum[6:0]] <= expB;
      end
      mPc <= expNextPc;
    end
  end

  // ========================================================================
  // compare assertions
  // ========================================================================

  task reportMismatch(input string name, input logic [31:0] expected,
                      input logic [31:0] actual);
    $display("Fail at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  resetPc: assert property (@(posedge clk) !rst |-> instrAddr == '0)
    else reportMismatch("instrAddr", 32'd0, $sampled(instrAddr));
  resetStore: assert property (@(posedge clk) !rst |-> !memWriteEn)
    else reportMismatch("memWriteEn", 32'd0, 32'($sampled(memWriteEn)));

  pcMatch: assert property (@(posedge clk) disable iff (!rst) instrAddr == mPc)
    else reportMismatch("instrAddr", $sampled(mPc), $sampled(instrAddr));
  wbMatch: assert property (@(posedge clk) disable iff (!rst)
    expWrite |-> rfWriteData == expWb)
    else reportMismatch("rfWriteData", $sampled(expWb), $sampled(rfWriteData));
  storeMatch: assert property (@(posedge clk) disable iff (!rst) memWriteEn == expStore)
    else reportMismatch("memWriteEn", 32'($sampled(expStore)), 32'($sampled(memWriteEn)));
  // lw and sw both present the word index
  addrMatch: assert property (@(posedge clk) disable iff (!rst)
    (mInstr[31:26] == opSw || mInstr[31:26] == opLw) |-> memAddr == expSum[6:0])
    else reportMismatch("memAddr", 32'($sampled(expSum[6:0])), 32'($sampled(memAddr)));
  dataMatch: assert property (@(posedge clk) disable iff (!rst)
    expStore |-> memWriteData == expB)
    else reportMismatch("memWriteData", $sampled(expB), $sampled(memWriteData));

  // ========================================================================
  // program generation
  // ========================================================================

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] drawBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value     = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic logic [5:0] functFor(input logic [2:0] sel);
    case (sel)
      3'd0:    return fnAdd;
      3'd1:    return fnSub;
      3'd2:    return fnAnd;
      3'd3:    return fnOr;
      default: return fnSlt;
    endcase
  endfunction

  function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [5:0] fn);
    return {opR, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jType(input logic [5:0] op, input int wordIndex);
    return {op, 26'(wordIndex)};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[6'(progLen)] = word;
    progLen++;
  endtask

  task automatic emitRandomR(input int count);
    for (int k = 0; k < count; k++) begin
      emit(rType(5'(drawBits(4)), 5'(drawBits(4)), 5'(drawBits(4) + 1),
                 functFor(3'(drawBits(3)))));
    end
  endtask

  task automatic buildProgram();
    logic [15:0] offset;
    // r1..r8 loaded from the fill pattern, nothing else seeds registers
    for (int r = 1; r <= 8; r++) begin
      emit(iType(opLw, 5'd0, 5'(r), 16'(drawBits(16))));
    end
    emitRandomR(10);
    // write to r0, then read it back as an operand
    emit(rType(5'd1, 5'd2, 5'd0, fnAdd));
    emit(rType(5'd0, 5'd3, 5'd17, fnAdd));
    // store then load the same word
    offset = 16'(drawBits(16));
    emit(iType(opSw, 5'd5, 5'd4, offset));
    emit(iType(opLw, 5'd5, 5'd18, offset));
    // taken beq, then one that depends on the data
    emit(iType(opBeq, 5'd6, 5'd6, 16'd1));
    emit(rType(5'd1, 5'd1, 5'd19, fnAdd));
    emit(iType(opBeq, 5'd7, 5'd8, 16'd1));
    emit(rType(5'd2, 5'd2, 5'd19, fnAdd));
    emit(jType(opJ, progLen + 2));
    emit(rType(5'd1, 5'd1, 5'd20, fnAdd));
    emit(jType(opJal, progLen + 2));
    emit(rType(5'd1, 5'd1, 5'd21, fnAdd));
    // unknown funct aimed at r31, the return address must survive it
    emit(rType(5'd1, 5'd2, 5'd31, 6'b000111));
    emit(rType(5'd31, 5'd0, 5'd22, fnAdd));
    offset = 16'(drawBits(16));
    emit(iType(opSw, 5'd0, 5'd22, offset));
    emit(iType(opLw, 5'd0, 5'd23, offset));
    emitRandomR(4);
    // jump to self marks the end
    haltIndex = progLen;
    emit(jType(opJ, progLen));
  endtask

  // ========================================================================
  // run control
  // ========================================================================

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= maxCycles) begin
      $display("timeout: the program did not reach its final jump in %0d cycles", maxCycles);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  always @(negedge clk) begin
    if (UUT.pcWriteChk.failCount != 0) begin
      $display("the bound checker saw a pc sequencing or write gating error");
      $display("Simulation FAILED");
      $fatal(1, "checker error");
    end
  end

  initial begin
    clk       = 1'b0;
    rst       = 1'b0;
    lfsrState = 32'he135;
    progLen   = 0;
    buildProgram();
    repeat (resetCycles) @(negedge clk);
    rst = 1'b1;
    while (instrAddr != 32'(haltIndex * 4)) begin
      @(negedge clk);
    end
    // let the final jump be checked too
    repeat (2) @(negedge clk);
    if (UUT.pcWriteChk.failCount == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "checker error");
    end
  end

endmodule

/* tests/mipsCore_chk.sv */
// ==========================================================================
// mipsCore_chk
// bound checker for pc sequencing and the memory and register write gating
// ==========================================================================

module mipsCore_chk (
  input logic                          clk,
  input logic                          rst,
  input logic [mipsPkg::dataWidth-1:0] instr,
  input logic [mipsPkg::dataWidth-1:0] instrAddr,
  input logic                          memWriteEn,
  input logic                          regWriteEn
);
  timeunit 1ns;
  timeprecision 100ps;
  import mipsPkg::*;

  // read by the testbench top
  int failCount = 0;

  logic [5:0]           opcode;
  logic [dataWidth-1:0] seqNext;
  logic [dataWidth-1:0] branchTarget;
  logic [dataWidth-1:0] jumpTarget;

  assign opcode       = instr[31:26];
  assign seqNext      = instrAddr + dataWidth'(4);
  assign branchTarget = seqNext + {{(dataWidth-18){instr[15]}}, instr[15:0], 2'b00};
  assign jumpTarget   = {seqNext[dataWidth-1:dataWidth-4], instr[25:0], 2'b00};

  // ========================================================================
  // pc sequencing
  // ========================================================================

  straightLine: assert property (@(posedge clk) disable iff (!rst)
    (opcode != opBeq && opcode != opJ && opcode != opJal) |=> instrAddr == $past(seqNext))
    else begin $error("pc did not advance by one word"); failCount++; end

  // either outcome is legal here, the model decides which one
  branchStep: assert property (@(posedge clk) disable iff (!rst)
    (opcode == opBeq) |=>
      (instrAddr == $past(seqNext) || instrAddr == $past(branchTarget)))
    else begin $error("beq went neither to pc + 4 nor to its target"); failCount++; end

  jumpStep: assert property (@(posedge clk) disable iff (!rst)
    (opcode == opJ || opcode == opJal) |=> instrAddr == $past(jumpTarget))
    else begin $error("jump missed its pseudo-direct target"); failCount++; end

  // ========================================================================
  // write gating
  // ========================================================================

  resetWrites: assert property (@(posedge clk) !rst |-> (!memWriteEn && !regWriteEn))
    else begin $error("write enable active while in reset"); failCount++; end

  storeOnly: assert property (@(posedge clk) disable iff (!rst)
    memWriteEn |-> opcode == opSw)
    else begin $error("memory write from an instruction other than sw"); failCount++; end

endmodule
